// File: verilog/pito_defines.svh
`ifndef PITO_DEFINES_SVH
`define PITO_DEFINES_SVH

// ==============================
// barrel configuration
// ==============================
// one instruction per hart every NUM_HARTS cycles
// must stay >= pipeline depth (5), no forwarding in the core
`define PITO_NUM_HARTS 8
`define PITO_HART_BITS 3

// ==============================
// memories
// ==============================
// depths in 32-bit words
`define PITO_IMEM_WORDS     256
`define PITO_IMEM_ADDR_BITS 8
`define PITO_DMEM_WORDS     256
`define PITO_DMEM_ADDR_BITS 8

// byte address every hart starts from
`define PITO_RESET_ADDRESS 32'h0000_0000
// byte address of data word 0 for loads and stores
`define PITO_DMEM_OFFSET   32'h0000_0000

`endif

// File: verilog/pito_pkg.sv
`include "pito_defines.svh"

package pito_pkg;

    // ==============================
    // widths
    // ==============================
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] instr_t;
    // byte address, low two bits always zero
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [`PITO_HART_BITS-1:0]      hart_id_t;
    // word addresses of the two memories
    typedef logic [`PITO_IMEM_ADDR_BITS-1:0] imem_addr_t;
    typedef logic [`PITO_DMEM_ADDR_BITS-1:0] dmem_addr_t;

    // ==============================
    // decoded instructions
    // ==============================
    // anything outside the subset decodes as OP_NOP
    typedef enum logic [4:0] {
        OP_NOP,
        // register forms
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
        // immediate forms
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        // upper immediate and word memory access
        OP_LUI, OP_LW, OP_SW,
        // control flow
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL
    } opcode_e;

    // shared alu operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

endpackage

// File: verilog/pito_alu.sv
`timescale 1ns/1ps

module pito_alu import pito_pkg::*; (
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    input  alu_op_e op_i,
    output xlen_t   res_o
);

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  res_o = a_i + b_i;
            ALU_SUB:  res_o = a_i - b_i;
            ALU_AND:  res_o = a_i & b_i;
            ALU_OR:   res_o = a_i | b_i;
            ALU_XOR:  res_o = a_i ^ b_i;
            // compares give 0 or 1
            ALU_SLT:  res_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: res_o = {31'd0, a_i < b_i};
            ALU_SLL:  res_o = a_i << shamt;
            ALU_SRL:  res_o = a_i >> shamt;
            ALU_SRA:  res_o = xlen_t'($signed(a_i) >>> shamt);
            default:  res_o = a_i + b_i;
        endcase
    end

endmodule

// File: verilog/pito_decoder.sv
`timescale 1ns/1ps

module pito_decoder import pito_pkg::*; (
    input  instr_t     instr_i,
    output reg_addr_t  rs1_o,
    output reg_addr_t  rs2_o,
    output reg_addr_t  rd_o,
    output xlen_t      imm_o,
    output logic [4:0] shamt_o,
    output opcode_e    opcode_o,
    output alu_op_e    alu_op_o
);

    // major opcodes of the kept subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_legal;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opc    = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // register fields sit at fixed spots
    assign rs1_o   = instr_i[19:15];
    assign rs2_o   = instr_i[24:20];
    assign rd_o    = instr_i[11:7];
    assign shamt_o = instr_i[24:20];

    // all immediates sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'd0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // funct7 is 0, or 0x20 on sub and the arithmetic shifts
    assign f7_legal = (funct7 == 7'b0000000) ||
                      ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

    always_comb begin
        case (opc)
            OPC_STORE:  imm_o = imm_s;
            OPC_BRANCH: imm_o = imm_b;
            OPC_LUI:    imm_o = imm_u;
            OPC_JAL:    imm_o = imm_j;
            default:    imm_o = imm_i;
        endcase
    end

    // funct3 picks the alu op for register and immediate forms alike
    // loads and stores use add for the address
    always_comb begin
        alu_op_o = ALU_ADD;
        if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
            case (funct3)
                3'b000:  alu_op_o = ((opc == OPC_OP) && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op_o = ALU_SLL;
                3'b010:  alu_op_o = ALU_SLT;
                3'b011:  alu_op_o = ALU_SLTU;
                3'b100:  alu_op_o = ALU_XOR;
                3'b101:  alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op_o = ALU_OR;
                default: alu_op_o = ALU_AND;
            endcase
        end
    end

    always_comb begin
        opcode_o = OP_NOP;
        case (opc)
            OPC_OP: begin
                if (f7_legal) begin
                    case (funct3)
                        3'b000:  opcode_o = funct7[5] ? OP_SUB : OP_ADD;
                        3'b001:  opcode_o = OP_SLL;
                        3'b010:  opcode_o = OP_SLT;
                        3'b011:  opcode_o = OP_SLTU;
                        3'b100:  opcode_o = OP_XOR;
                        3'b101:  opcode_o = funct7[5] ? OP_SRA : OP_SRL;
                        3'b110:  opcode_o = OP_OR;
                        default: opcode_o = OP_AND;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  opcode_o = OP_ADDI;
                    3'b010:  opcode_o = OP_SLTI;
                    3'b100:  opcode_o = OP_XORI;
                    3'b110:  opcode_o = OP_ORI;
                    3'b111:  opcode_o = OP_ANDI;
                    3'b001:  opcode_o = (funct7 == 7'b0000000) ? OP_SLLI : OP_NOP;
                    3'b101:  opcode_o = !f7_legal ? OP_NOP : (funct7[5] ? OP_SRAI : OP_SRLI);
                    // sltiu is not kept
                    default: opcode_o = OP_NOP;
                endcase
            end
            OPC_LUI:   opcode_o = OP_LUI;
            OPC_LOAD:  opcode_o = (funct3 == 3'b010) ? OP_LW : OP_NOP;
            OPC_STORE: opcode_o = (funct3 == 3'b010) ? OP_SW : OP_NOP;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  opcode_o = OP_BEQ;
                    3'b001:  opcode_o = OP_BNE;
                    3'b100:  opcode_o = OP_BLT;
                    3'b101:  opcode_o = OP_BGE;
                    default: opcode_o = OP_NOP;
                endcase
            end
            OPC_JAL:   opcode_o = OP_JAL;
            default:   opcode_o = OP_NOP;
        endcase
    end

endmodule

// File: verilog/pito_regfiles.sv
`timescale 1ns/1ps
`include "pito_defines.svh"

module pito_regfiles import pito_pkg::*; (
    input  logic      clk,
    input  hart_id_t  rd_hart_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    output xlen_t     rd1_o,
    output xlen_t     rd2_o,
    input  hart_id_t  wr_hart_i,
    input  logic      we_i,
    input  reg_addr_t wa_i,
    input  xlen_t     wd_i
);

    // one bank of 32 per hart
    xlen_t regs_q [`PITO_NUM_HARTS][32];

    // reads for the hart in decode, x0 hardwired
    assign rd1_o = (ra1_i == 5'd0) ? '0 : regs_q[rd_hart_i][ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? '0 : regs_q[rd_hart_i][ra2_i];

    // write for the hart in the write stage
    always_ff @(posedge clk) begin
        if (we_i) begin
            regs_q[wr_hart_i][wa_i] <= wd_i;
        end
    end

endmodule

// File: verilog/pito_hart_ctrl.sv
`timescale 1ns/1ps
`include "pito_defines.svh"

module pito_hart_ctrl import pito_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output pc_t      fetch_pc_o,
    output hart_id_t fetch_hart_o,
    input  hart_id_t wb_hart_i,
    input  opcode_e  wb_opcode_i,
    input  pc_t      wb_pc_i,
    input  xlen_t    wb_imm_i,
    input  xlen_t    wb_rs1_i,
    input  xlen_t    wb_rs2_i,
    output pc_t      link_pc_o
);

    hart_id_t   hart_cnt_q;
    pc_t        pc_q [`PITO_NUM_HARTS];
    // pipeline fill, bit 2 set once memory/write-back holds a real hart
    logic [2:0] fill_q;
    logic       taken;
    pc_t        next_pc;

    // ==============================
    // round robin hart counter
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_cnt_q <= '0;
        end else if (hart_cnt_q == hart_id_t'(`PITO_NUM_HARTS - 1)) begin
            hart_cnt_q <= '0;
        end else begin
            hart_cnt_q <= hart_cnt_q + 1'b1;
        end
    end

    assign fetch_hart_o = hart_cnt_q;
    assign fetch_pc_o   = pc_q[hart_cnt_q];

    // ==============================
    // branch and jump decision
    // ==============================
    always_comb begin
        case (wb_opcode_i)
            OP_BEQ:  taken = (wb_rs1_i == wb_rs2_i);
            OP_BNE:  taken = (wb_rs1_i != wb_rs2_i);
            OP_BLT:  taken = ($signed(wb_rs1_i) < $signed(wb_rs2_i));
            OP_BGE:  taken = ($signed(wb_rs1_i) >= $signed(wb_rs2_i));
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // return address for jal, also the fall-through pc
    assign link_pc_o = wb_pc_i + 32'd4;
    assign next_pc   = taken ? (wb_pc_i + wb_imm_i) : link_pc_o;

    // ==============================
    // per hart pc
    // ==============================
    // hart in memory/write-back is fetched again 5 cycles later,
    // so the update is always in time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_q <= '0;
            for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                pc_q[h] <= `PITO_RESET_ADDRESS;
            end
        end else begin
            fill_q <= {fill_q[1:0], 1'b1};
            if (fill_q[2]) begin
                pc_q[wb_hart_i] <= next_pc;
            end
        end
    end

endmodule

// File: verilog/pito_word_mem.sv
`timescale 1ns/1ps

module pito_word_mem import pito_pkg::*; #(
    parameter int WORDS = 256
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(WORDS)-1:0] addr_i,
    input  xlen_t                    wdata_i,
    output xlen_t                    rdata_o
);

    xlen_t mem_q [WORDS];

    // one port, read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];
    end

endmodule

// File: verilog/pito_core.sv
`timescale 1ns/1ps
`include "pito_defines.svh"

module pito_core import pito_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       imem_we_i,
    input  imem_addr_t imem_addr_i,
    input  instr_t     imem_wdata_i,
    input  logic       dmem_prog_i,
    input  logic       dmem_we_i,
    input  dmem_addr_t dmem_addr_i,
    input  xlen_t      dmem_wdata_i,
    output xlen_t      dmem_rdata_o
);

    // fetch
    pc_t        fetch_pc;
    hart_id_t   fetch_hart;
    imem_addr_t imem_addr;
    logic       imem_we;
    instr_t     instr;
    // decode
    logic       dec_valid_q;
    hart_id_t   dec_hart_q;
    pc_t        dec_pc_q;
    reg_addr_t  dec_rs1;
    reg_addr_t  dec_rs2;
    reg_addr_t  dec_rd;
    xlen_t      dec_imm;
    logic [4:0] dec_shamt;
    opcode_e    dec_opcode;
    alu_op_e    dec_alu_op;
    xlen_t      rf_rd1;
    xlen_t      rf_rd2;
    xlen_t      dec_alu_b;
    // execute
    hart_id_t   ex_hart_q;
    opcode_e    ex_opcode_q;
    pc_t        ex_pc_q;
    xlen_t      ex_imm_q;
    reg_addr_t  ex_rd_q;
    xlen_t      ex_rs1_q;
    xlen_t      ex_rs2_q;
    xlen_t      ex_alu_b_q;
    alu_op_e    ex_alu_op_q;
    xlen_t      alu_res;
    // memory/write-back
    hart_id_t   wb_hart_q;
    opcode_e    wb_opcode_q;
    pc_t        wb_pc_q;
    xlen_t      wb_imm_q;
    reg_addr_t  wb_rd_q;
    xlen_t      wb_rs1_q;
    xlen_t      wb_rs2_q;
    xlen_t      wb_alu_q;
    logic       dmem_store_q;
    pc_t        link_pc;
    logic       wb_writes_rd;
    xlen_t      wb_wd;
    xlen_t      dmem_byte;
    dmem_addr_t dmem_addr;
    logic       dmem_we;
    xlen_t      dmem_wdata;
    // register-file write
    hart_id_t   wf_hart_q;
    logic       wf_we_q;
    reg_addr_t  wf_wa_q;
    logic       wf_is_load_q;
    xlen_t      wf_wd_q;
    xlen_t      rf_wd;

    pito_hart_ctrl hart_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_pc_o   (fetch_pc),
        .fetch_hart_o (fetch_hart),
        .wb_hart_i    (wb_hart_q),
        .wb_opcode_i  (wb_opcode_q),
        .wb_pc_i      (wb_pc_q),
        .wb_imm_i     (wb_imm_q),
        .wb_rs1_i     (wb_rs1_q),
        .wb_rs2_i     (wb_rs2_q),
        .link_pc_o    (link_pc)
    );

    // ==============================
    // fetch
    // ==============================
    // io side loads the program while reset is held
    assign imem_addr = rst_n ? fetch_pc[`PITO_IMEM_ADDR_BITS+1:2] : imem_addr_i;
    assign imem_we   = imem_we_i & ~rst_n;

    pito_word_mem #(.WORDS(`PITO_IMEM_WORDS)) i_mem (
        .clk     (clk),
        .we_i    (imem_we),
        .addr_i  (imem_addr),
        .wdata_i (imem_wdata_i),
        .rdata_o (instr)
    );

    // ==============================
    // decode
    // ==============================
    pito_decoder decoder (
        .instr_i  (instr),
        .rs1_o    (dec_rs1),
        .rs2_o    (dec_rs2),
        .rd_o     (dec_rd),
        .imm_o    (dec_imm),
        .shamt_o  (dec_shamt),
        .opcode_o (dec_opcode),
        .alu_op_o (dec_alu_op)
    );

    pito_regfiles regfiles (
        .clk       (clk),
        .rd_hart_i (dec_hart_q),
        .ra1_i     (dec_rs1),
        .ra2_i     (dec_rs2),
        .rd1_o     (rf_rd1),
        .rd2_o     (rf_rd2),
        .wr_hart_i (wf_hart_q),
        .we_i      (wf_we_q),
        .wa_i      (wf_wa_q),
        .wd_i      (rf_wd)
    );

    // second alu operand
    always_comb begin
        case (dec_opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA:
                dec_alu_b = rf_rd2;
            OP_SLLI, OP_SRLI, OP_SRAI:
                dec_alu_b = {27'd0, dec_shamt};
            default:
                dec_alu_b = dec_imm;
        endcase
    end

    // ==============================
    // execute and memory/write-back
    // ==============================
    pito_alu alu (
        .a_i   (ex_rs1_q),
        .b_i   (ex_alu_b_q),
        .op_i  (ex_alu_op_q),
        .res_o (alu_res)
    );

    // first decode after reset sees a stale memory word, squash it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid_q  <= 1'b0;
            ex_opcode_q  <= OP_NOP;
            wb_opcode_q  <= OP_NOP;
            dmem_store_q <= 1'b0;
            wf_we_q      <= 1'b0;
        end else begin
            dec_valid_q  <= 1'b1;
            ex_opcode_q  <= dec_valid_q ? dec_opcode : OP_NOP;
            wb_opcode_q  <= ex_opcode_q;
            dmem_store_q <= (ex_opcode_q == OP_SW);
            // x0 writes dropped here
            wf_we_q      <= wb_writes_rd && (wb_rd_q != 5'd0);
        end
    end

    // stage payload, each stage tagged with its hart
    always_ff @(posedge clk) begin
        dec_hart_q   <= fetch_hart;
        dec_pc_q     <= fetch_pc;
        ex_hart_q    <= dec_hart_q;
        ex_pc_q      <= dec_pc_q;
        ex_imm_q     <= dec_imm;
        ex_rd_q      <= dec_rd;
        ex_rs1_q     <= rf_rd1;
        ex_rs2_q     <= rf_rd2;
        ex_alu_b_q   <= dec_alu_b;
        ex_alu_op_q  <= dec_alu_op;
        wb_hart_q    <= ex_hart_q;
        wb_pc_q      <= ex_pc_q;
        wb_imm_q     <= ex_imm_q;
        wb_rd_q      <= ex_rd_q;
        wb_rs1_q     <= ex_rs1_q;
        wb_rs2_q     <= ex_rs2_q;
        wb_alu_q     <= alu_res;
        wf_hart_q    <= wb_hart_q;
        wf_wa_q      <= wb_rd_q;
        wf_is_load_q <= (wb_opcode_q == OP_LW);
        wf_wd_q      <= wb_wd;
    end

    // alu result is the byte address for both lw and sw
    assign dmem_byte = wb_alu_q - `PITO_DMEM_OFFSET;

    // program mode hands the data memory to the io side
    assign dmem_addr  = dmem_prog_i ? dmem_addr_i : dmem_byte[`PITO_DMEM_ADDR_BITS+1:2];
    assign dmem_we    = dmem_prog_i ? dmem_we_i : dmem_store_q;
    assign dmem_wdata = dmem_prog_i ? dmem_wdata_i : wb_rs2_q;

    pito_word_mem #(.WORDS(`PITO_DMEM_WORDS)) d_mem (
        .clk     (clk),
        .we_i    (dmem_we),
        .addr_i  (dmem_addr),
        .wdata_i (dmem_wdata),
        .rdata_o (dmem_rdata_o)
    );

    // which instructions write rd, and with what
    always_comb begin
        wb_writes_rd = 1'b1;
        wb_wd        = wb_alu_q;
        case (wb_opcode_q)
            OP_NOP, OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE: wb_writes_rd = 1'b0;
            OP_LUI:  wb_wd = wb_imm_q;
            OP_JAL:  wb_wd = link_pc;
            default: wb_wd = wb_alu_q;
        endcase
    end

    // ==============================
    // register-file write
    // ==============================
    // load word arrives from the data memory this cycle
    assign rf_wd = wf_is_load_q ? dmem_rdata_o : wf_wd_q;

endmodule

// File: tb/pito_core_assert.sv
`timescale 1ns/1ps
`include "pito_defines.svh"

module pito_core_assert import pito_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     store_i,
    input logic     rf_we_i,
    input hart_id_t hart_i,
    input pc_t      fetch_pc_i
);

    // read back by the testbench at the end of the run
    int unsigned fail_cnt = 0;
    hart_id_t    next_hart;

    // round robin wraps after the last hart
    assign next_hart = (hart_i == hart_id_t'(`PITO_NUM_HARTS - 1)) ? '0 : hart_i + hart_id_t'(1);

    // ==============================
    // checks
    // ==============================
    // nothing stored or written the cycle after a reset cycle
    reset_quiet: assert property (@(posedge clk) !rst_n |=> (!store_i && !rf_we_i))
        else begin
            fail_cnt++;
            $error("store strobe or register write enable high right after reset");
        end

    // one hart per cycle, strictly in turn
    hart_turn: assert property (@(posedge clk) disable iff (!rst_n)
        rst_n |=> (hart_i == $past(next_hart)))
        else begin
            fail_cnt++;
            $error("hart counter did not advance by one modulo the hart count");
        end

    // fetch pc on a word boundary
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_pc_i[1:0] == 2'b00)
        else begin
            fail_cnt++;
            $error("fetch pc is not word aligned");
        end

endmodule

// File: tb/pito_core_tb.sv
`timescale 1ns/1ps
`include "pito_defines.svh"

module pito_core_tb import pito_pkg::*; ();

    localparam int          NUM_TESTS = 5;
    localparam int          MAX_LEN   = 8;
    localparam logic [31:0] SEED      = 32'hdc797f33;
    // addi x0, x0, 0
    localparam instr_t      NOP       = 32'h0000_0013;
    localparam logic [6:0]  OPC_IMM   = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD  = 7'b0000011;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       imem_we_i;
    imem_addr_t imem_addr_i;
    instr_t     imem_wdata_i;
    logic       dmem_prog_i;
    logic       dmem_we_i;
    dmem_addr_t dmem_addr_i;
    xlen_t      dmem_wdata_i;
    xlen_t      dmem_rdata_o;

    // ==============================
    // stimulus table
    // ==============================
    string       test_name [NUM_TESTS];
    instr_t      prog      [NUM_TESTS][MAX_LEN];
    int          prog_len  [NUM_TESTS];
    logic        pre_en    [NUM_TESTS];
    dmem_addr_t  pre_addr  [NUM_TESTS];
    xlen_t       pre_data  [NUM_TESTS];
    dmem_addr_t  chk_addr  [NUM_TESTS];
    xlen_t       expected  [NUM_TESTS];
    int unsigned seed_val;
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0;

    pito_core pito_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .dmem_prog_i  (dmem_prog_i),
        .dmem_we_i    (dmem_we_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_wdata_i (dmem_wdata_i),
        .dmem_rdata_o (dmem_rdata_o)
    );

    bind pito_core pito_core_assert core_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .store_i    (dmem_store_q),
        .rf_we_i    (wf_we_q),
        .hart_i     (fetch_hart),
        .fetch_pc_i (fetch_pc)
    );

    // 8 ns period
    initial begin
        forever #4 clk = ~clk;
    end

    // run limit from the table lengths
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit)) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // ==============================
    // instruction encoders
    // ==============================
    function automatic instr_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                      reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only
    function automatic instr_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // lui
    function automatic instr_t u_type(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // jal
    function automatic instr_t j_type(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic int run_cycles(int len);
        return `PITO_NUM_HARTS * (len + 6);
    endfunction

    // ==============================
    // table build
    // ==============================
    task automatic build_table();
        logic [31:0] rnd;
        logic [19:0] up;
        logic [11:0] lo;
        logic [11:0] lo_b;
        logic [4:0]  sh_l;
        logic [4:0]  sh_r;
        logic [4:0]  sh_a;
        xlen_t       x1;
        xlen_t       x2;
        xlen_t       x3;
        xlen_t       x4;
        xlen_t       x5;
        for (int t = 0; t < NUM_TESTS; t++) begin
            pre_en[t] = 1'b0;
            for (int w = 0; w < MAX_LEN; w++) begin
                prog[t][w] = NOP;
            end
        end

        // lui/addi constants, sub xor slt add
        rnd = $urandom;
        up  = rnd[31:12];
        rnd = $urandom;
        lo  = rnd[11:0];
        x1  = {up, 12'd0};
        x2  = {{20{lo[11]}}, lo};
        x3  = x1 - x2;
        x4  = x3 ^ x1;
        // differing sign bits decide the order
        // same sign orders like unsigned
        x5  = (x1[31] != x2[31]) ? {31'd0, x1[31]} : {31'd0, (x1 < x2)};
        test_name[0] = "arith";
        prog[0][0]   = u_type(up, 5'd1);
        prog[0][1]   = i_type(lo, 5'd0, 3'b000, 5'd2, OPC_IMM);
        prog[0][2]   = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3);
        prog[0][3]   = r_type(7'h00, 5'd1, 5'd3, 3'b100, 5'd4);
        prog[0][4]   = r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd5);
        prog[0][5]   = r_type(7'h00, 5'd5, 5'd4, 3'b000, 5'd6);
        prog[0][6]   = s_type(12'd64, 5'd6, 5'd0);
        prog[0][7]   = j_type(21'd0, 5'd0);
        prog_len[0]  = 8;
        chk_addr[0]  = 8'd16;
        expected[0]  = x4 + x5;

        // negative constant, three shift kinds
        rnd  = $urandom;
        up   = {1'b1, rnd[18:0]};
        sh_l = 5'(($urandom % 31) + 1);
        sh_r = 5'(($urandom % 31) + 1);
        sh_a = 5'(($urandom % 31) + 1);
        x1   = {up, 12'd0};
        // x1 is negative so the vacated bits fill with ones
        x2   = (x1 >> sh_a) | ~(32'hffff_ffff >> sh_a);
        x3   = x1 >> sh_r;
        x4   = x1 << sh_l;
        test_name[1] = "shift";
        prog[1][0]   = u_type(up, 5'd1);
        prog[1][1]   = i_type({7'h20, sh_a}, 5'd1, 3'b101, 5'd2, OPC_IMM);
        prog[1][2]   = i_type({7'h00, sh_r}, 5'd1, 3'b101, 5'd3, OPC_IMM);
        prog[1][3]   = i_type({7'h00, sh_l}, 5'd1, 3'b001, 5'd4, OPC_IMM);
        prog[1][4]   = r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd5);
        prog[1][5]   = r_type(7'h00, 5'd4, 5'd5, 3'b000, 5'd5);
        prog[1][6]   = s_type(12'd68, 5'd5, 5'd0);
        prog[1][7]   = j_type(21'd0, 5'd0);
        prog_len[1]  = 8;
        chk_addr[1]  = 8'd17;
        expected[1]  = (x2 ^ x3) + x4;

        // preloaded word, lw, +1, sw elsewhere
        test_name[2] = "load";
        pre_en[2]    = 1'b1;
        pre_addr[2]  = 8'd32;
        pre_data[2]  = $urandom;
        prog[2][0]   = i_type(12'd128, 5'd0, 3'b010, 5'd1, OPC_LOAD);
        prog[2][1]   = i_type(12'd1, 5'd1, 3'b000, 5'd2, OPC_IMM);
        prog[2][2]   = s_type(12'd132, 5'd2, 5'd0);
        prog[2][3]   = j_type(21'd0, 5'd0);
        prog_len[2]  = 4;
        chk_addr[2]  = 8'd33;
        expected[2]  = pre_data[2] + 32'd1;

        // bne taken skips +1, beq not taken keeps +2
        rnd  = $urandom;
        lo   = rnd[11:0];
        lo_b = lo ^ 12'(($urandom % 4095) + 1);
        test_name[3] = "branch";
        prog[3][0]   = i_type(lo, 5'd0, 3'b000, 5'd1, OPC_IMM);
        prog[3][1]   = i_type(lo_b, 5'd0, 3'b000, 5'd2, OPC_IMM);
        prog[3][2]   = b_type(13'd8, 5'd2, 5'd1, 3'b001);
        prog[3][3]   = i_type(12'd1, 5'd1, 3'b000, 5'd1, OPC_IMM);
        prog[3][4]   = b_type(13'd8, 5'd2, 5'd1, 3'b000);
        prog[3][5]   = i_type(12'd2, 5'd1, 3'b000, 5'd1, OPC_IMM);
        prog[3][6]   = s_type(12'd72, 5'd1, 5'd0);
        prog[3][7]   = j_type(21'd0, 5'd0);
        prog_len[3]  = 8;
        chk_addr[3]  = 8'd18;
        expected[3]  = {{20{lo[11]}}, lo} + 32'd2;

        // jal at byte 4 over two addi, link into x1
        test_name[4] = "jal";
        prog[4][0]   = NOP;
        prog[4][1]   = j_type(21'd12, 5'd1);
        prog[4][2]   = i_type(12'd1, 5'd0, 3'b000, 5'd1, OPC_IMM);
        prog[4][3]   = i_type(12'd2, 5'd0, 3'b000, 5'd1, OPC_IMM);
        prog[4][4]   = s_type(12'd76, 5'd1, 5'd0);
        prog[4][5]   = j_type(21'd0, 5'd0);
        prog_len[4]  = 6;
        chk_addr[4]  = 8'd19;
        expected[4]  = 32'd4 + 32'd4;
    endtask

    // ==============================
    // io side helpers
    // ==============================
    // whole imem rewritten under reset, unused words as nop
    task automatic load_program(input int t);
        rst_n = 1'b0;
        for (int w = 0; w < `PITO_IMEM_WORDS; w++) begin
            @(negedge clk);
            imem_we_i    = 1'b1;
            imem_addr_i  = imem_addr_t'(w);
            imem_wdata_i = (w < prog_len[t]) ? prog[t][w] : NOP;
        end
        @(negedge clk);
        imem_we_i = 1'b0;
        if (pre_en[t]) begin
            dmem_prog_i  = 1'b1;
            dmem_we_i    = 1'b1;
            dmem_addr_i  = pre_addr[t];
            dmem_wdata_i = pre_data[t];
            @(negedge clk);
            dmem_prog_i = 1'b0;
            dmem_we_i   = 1'b0;
        end
    endtask

    // data shows one cycle after the address
    task automatic read_word(input dmem_addr_t addr, output xlen_t data);
        dmem_prog_i = 1'b1;
        dmem_we_i   = 1'b0;
        dmem_addr_i = addr;
        @(negedge clk);
        data        = dmem_rdata_o;
        dmem_prog_i = 1'b0;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        xlen_t got;
        int    total;
        rst_n        = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        dmem_prog_i  = 1'b0;
        dmem_we_i    = 1'b0;
        dmem_addr_i  = '0;
        dmem_wdata_i = '0;
        seed_val     = $urandom(SEED);
        build_table();

        // load, reset hold, run and readback per row
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += run_cycles(prog_len[t]) + `PITO_IMEM_WORDS + 16;
        end
        cycle_limit = total + 200;

        for (int t = 0; t < NUM_TESTS; t++) begin
            load_program(t);
            repeat (2) @(negedge clk);
            rst_n = 1'b1;
            // every hart ends in its jal loop by now
            repeat (run_cycles(prog_len[t])) @(negedge clk);
            read_word(chk_addr[t], got);
            assert (got === expected[t])
                else begin
                    $display("Mismatch in test %s: expected %08h, actual %08h",
                             test_name[t], expected[t], got);
                    $display("Verification failed");
                    $fatal(1, "stopped at the first error");
                end
            rst_n = 1'b0;
        end

        if (pito_core_i.core_assert.fail_cnt != 0) begin
            $display("Bound assertions on the core failed %0d times",
                     pito_core_i.core_assert.fail_cnt);
            $display("Verification failed");
            $fatal(1, "stopped on assertion failures");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/pito_pkg.sv
verilog/pito_alu.sv
verilog/pito_decoder.sv
verilog/pito_regfiles.sv
verilog/pito_hart_ctrl.sv
verilog/pito_word_mem.sv
verilog/pito_core.sv
tb/pito_core_assert.sv
tb/pito_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := pito_core_tb
RTL_TOP    := pito_core
FILELIST   := verilog.f
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
